// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // bus geometry
    localparam int NUM_CACHES  = 4;
    localparam int CACHE_ID_W  = $clog2(NUM_CACHES);
    localparam int BUS_WORDS   = 2;
    localparam int DATA_W      = 32 * BUS_WORDS;
    localparam int ADDR_W      = 32;

    // one request in flight per cache, so this depth never overflows
    localparam int QUEUE_DEPTH = NUM_CACHES;

    // request opcodes posted by the caches
    typedef enum logic [1:0] {
        op_load,
        op_ld_exclusive,
        op_up_exclusive,
        op_write_back
    } bus_req_type_t;

    // transaction controller states
    typedef enum logic [1:0] {
        s_ready,
        s_wait,
        s_xmem
    } bus_state_t;

endpackage

`default_nettype wire

// ==== priority_lru.sv ====
`timescale 1ns/1ps
`default_nettype none

module priority_lru (
    input  logic                                                  clk_i,
    input  logic                                                  nreset_i,
    input  logic                                                  valid_i,
    input  logic [bus_pkg::CACHE_ID_W-1:0]                        index_i,
    output logic [bus_pkg::NUM_CACHES-1:0][bus_pkg::CACHE_ID_W-1:0] priority_o
);

    import bus_pkg::*;

    logic [NUM_CACHES-1:0][CACHE_ID_W-1:0] rank_r;
    logic [CACHE_ID_W-1:0]                 sel_rank;
    logic [NUM_CACHES-1:0]                 rank_seen;

    assign sel_rank   = rank_r[index_i];
    assign priority_o = rank_r;

    // granted cache drops to rank 0, the ones ahead of it shift up
    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            for (int c = 0; c < NUM_CACHES; c++) begin
                rank_r[c] <= CACHE_ID_W'(c);
            end
        end else if (valid_i) begin
            for (int c = 0; c < NUM_CACHES; c++) begin
                if (CACHE_ID_W'(c) == index_i) begin
                    rank_r[c] <= '0;
                end else if (rank_r[c] < sel_rank) begin
                    rank_r[c] <= rank_r[c] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rank_seen = '0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            rank_seen[rank_r[c]] = 1'b1;
        end
    end

    a_rank_permutation: assert property (@(posedge clk_i) disable iff (nreset_i)
        &rank_seen)
        else $error("priority ranks are not a permutation");

endmodule

`default_nettype wire

// ==== id_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_fifo #(
    parameter int width_p = bus_pkg::CACHE_ID_W
) (
    input  logic               clk_i,
    input  logic               nreset_i,
    input  logic               wr_i,
    input  logic               rd_i,
    input  logic [width_p-1:0] wdata_i,
    output logic [width_p-1:0] rdata_o,
    output logic               full_o,
    output logic               empty_o
);

    import bus_pkg::*;

    logic [width_p-1:0]    mem_r [QUEUE_DEPTH];
    logic [CACHE_ID_W-1:0] wr_ptr_r;
    logic [CACHE_ID_W-1:0] rd_ptr_r;
    logic [CACHE_ID_W:0]   count_r;

    assign rdata_o = mem_r[rd_ptr_r];
    assign full_o  = count_r == (CACHE_ID_W + 1)'(QUEUE_DEPTH);
    assign empty_o = count_r == '0;

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            mem_r[wr_ptr_r] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (wr_i) begin
                wr_ptr_r <= (wr_ptr_r == CACHE_ID_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (rd_i) begin
                rd_ptr_r <= (rd_ptr_r == CACHE_ID_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            // count holds when both sides move in the same cycle
            if (wr_i && !rd_i) begin
                count_r <= count_r + 1'b1;
            end else if (rd_i && !wr_i) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (nreset_i)
        wr_i |-> (!full_o || rd_i))
        else $error("write to full queue");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (nreset_i)
        rd_i |-> !empty_o)
        else $error("read from empty queue");

endmodule

`default_nettype wire

// ==== bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                           clk_i,
    input  logic                           nreset_i,
    input  logic [bus_pkg::NUM_CACHES-1:0] cb_valid_i,
    input  logic                           out_full_i,
    input  logic                           out_deq_i,
    input  logic [bus_pkg::CACHE_ID_W-1:0] done_id_i,
    output logic                           grant_valid_o,
    output logic [bus_pkg::CACHE_ID_W-1:0] grant_id_o
);

    import bus_pkg::*;

    logic [NUM_CACHES-1:0][CACHE_ID_W-1:0] lru_rank;
    logic [NUM_CACHES-1:0]                 pending_r;
    logic [NUM_CACHES-1:0]                 valid_req;
    logic [NUM_CACHES-1:0]                 pending_set;
    logic [NUM_CACHES-1:0]                 pending_clr;
    logic [CACHE_ID_W-1:0]                 best_rank;
    logic                                  sel_found;
    logic                                  out_accept;

    priority_lru u_priority_lru (
        .clk_i      (clk_i),
        .nreset_i   (nreset_i),
        .valid_i    (grant_valid_o),
        .index_i    (grant_id_o),
        .priority_o (lru_rank)
    );

    // a cache with a request already queued is not considered again
    assign valid_req  = cb_valid_i & ~pending_r;
    assign out_accept = ~out_full_i | out_deq_i;

    // highest rank is the least recently granted requester
    always_comb begin
        sel_found  = 1'b0;
        best_rank  = '0;
        grant_id_o = '0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (valid_req[c] && (!sel_found || lru_rank[c] > best_rank)) begin
                sel_found  = 1'b1;
                best_rank  = lru_rank[c];
                grant_id_o = CACHE_ID_W'(c);
            end
        end
    end

    assign grant_valid_o = sel_found & out_accept;

    assign pending_set = {NUM_CACHES{grant_valid_o}} & (NUM_CACHES'(1) << grant_id_o);
    assign pending_clr = {NUM_CACHES{out_deq_i}} & (NUM_CACHES'(1) << done_id_i);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            pending_r <= '0;
        end else begin
            pending_r <= (pending_r & ~pending_clr) | pending_set;
        end
    end

endmodule

`default_nettype wire

// ==== bus_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_controller (
    input  logic                                              clk_i,
    input  logic                                              nreset_i,
    input  logic                                              out_empty_i,
    input  logic [bus_pkg::CACHE_ID_W-1:0]                    head_id_i,
    output logic                                              out_deq_o,
    input  bus_pkg::bus_req_type_t [bus_pkg::NUM_CACHES-1:0]  cb_req_type_i,
    input  logic [bus_pkg::NUM_CACHES-1:0][bus_pkg::ADDR_W-1:0] cb_addr_i,
    input  logic [bus_pkg::NUM_CACHES-1:0][bus_pkg::DATA_W-1:0] cb_wdata_i,
    input  logic [bus_pkg::NUM_CACHES-1:0]                    sb_wait_i,
    input  logic [bus_pkg::NUM_CACHES-1:0]                    sb_hit_i,
    output logic [bus_pkg::NUM_CACHES-1:0]                    sb_valid_o,
    output logic                                              sb_tx_begin_o,
    output logic [bus_pkg::ADDR_W-1:0]                        sb_addr_o,
    output bus_pkg::bus_req_type_t                            sb_req_type_o,
    input  logic                                              mem_ready_i,
    output logic                                              mem_valid_o,
    output logic                                              mem_we_o,
    output logic [bus_pkg::ADDR_W-1:0]                        mem_addr_o,
    output logic [bus_pkg::DATA_W-1:0]                        mem_wdata_o,
    input  logic                                              mem_valid_i,
    input  logic [bus_pkg::DATA_W-1:0]                        mem_data_i,
    output logic [bus_pkg::NUM_CACHES-1:0]                    cb_yumi_o,
    output logic [bus_pkg::NUM_CACHES-1:0]                    cb_valid_o,
    output logic [bus_pkg::DATA_W-1:0]                        cb_data_o,
    output logic                                              cb_ld_ex_o
);

    import bus_pkg::*;

    bus_state_t            state_r, state_n;
    bus_req_type_t         cur_type;
    logic [ADDR_W-1:0]     cur_addr;
    logic [NUM_CACHES-1:0] head_dec, rx_dec;
    logic                  tx_begin, active, snoop_wait, wait_done, hit_now;
    logic                  is_up, is_wb, is_read, up_done, mem_fire;
    logic                  shared_r;
    logic                  in_enq, in_full, in_empty, in_ready, rx_shared;
    logic [CACHE_ID_W-1:0] rx_id;

    assign cur_type = cb_req_type_i[head_id_i];
    assign cur_addr = cb_addr_i[head_id_i];
    assign head_dec = NUM_CACHES'(1) << head_id_i;
    assign rx_dec   = NUM_CACHES'(1) << rx_id;

    assign is_up   = cur_type == op_up_exclusive;
    assign is_wb   = cur_type == op_write_back;
    assign is_read = !is_up && !is_wb;

    // snoop broadcast to everyone but the requester
    assign tx_begin      = (state_r == s_ready) && !out_empty_i;
    assign active        = (state_r != s_ready) || tx_begin;
    assign sb_tx_begin_o = tx_begin;
    assign sb_valid_o    = active ? ~head_dec : '0;
    assign sb_addr_o     = active ? cur_addr : '0;
    assign sb_req_type_o = active ? cur_type : op_load;

    assign snoop_wait = |(sb_wait_i & ~head_dec);
    assign wait_done  = (state_r == s_wait) && !snoop_wait;
    assign hit_now    = (state_r == s_wait) && |(sb_hit_i & ~head_dec);

    // in queue must have room before a read goes out
    assign in_ready = !in_full || mem_valid_i;
    assign up_done  = wait_done && is_up;
    assign mem_fire = (state_r == s_xmem) && mem_ready_i && (is_wb || in_ready);
    assign in_enq   = mem_fire && is_read;

    assign mem_valid_o = mem_fire;
    assign mem_we_o    = mem_fire && is_wb;
    assign mem_addr_o  = cur_addr;
    assign mem_wdata_o = cb_wdata_i[head_id_i];

    assign out_deq_o = up_done || mem_fire;
    assign cb_yumi_o = {NUM_CACHES{out_deq_o}} & head_dec;

    // memory responses go to the in queue head, upgrades are answered at once
    assign cb_valid_o = ({NUM_CACHES{mem_valid_i}} & rx_dec) | ({NUM_CACHES{up_done}} & head_dec);
    assign cb_data_o  = mem_data_i;
    assign cb_ld_ex_o = mem_valid_i ? !rx_shared : 1'b1;

    always_comb begin
        state_n = state_r;
        case (state_r)
            s_ready: if (tx_begin) state_n = s_wait;
            s_wait:  if (!snoop_wait) state_n = is_up ? s_ready : s_xmem;
            s_xmem:  if (mem_fire) state_n = s_ready;
            default: state_n = s_ready;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r  <= s_ready;
            shared_r <= 1'b0;
        end else begin
            state_r  <= state_n;
            shared_r <= hit_now || (shared_r && state_r != s_ready);
        end
    end

    id_fifo #(
        .width_p (CACHE_ID_W + 1)
    ) u_in_queue (
        .clk_i    (clk_i),
        .nreset_i (nreset_i),
        .wr_i     (in_enq),
        .rd_i     (mem_valid_i),
        .wdata_i  ({shared_r, head_id_i}),
        .rdata_o  ({rx_shared, rx_id}),
        .full_o   (in_full),
        .empty_o  (in_empty)
    );

    a_resp_expected: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_i |-> !in_empty)
        else $error("memory response with no outstanding read");

    a_yumi_onehot: assert property (@(posedge clk_i) disable iff (nreset_i)
        $onehot0(cb_yumi_o))
        else $error("more than one yumi in a cycle");

endmodule

`default_nettype wire

// ==== snoop_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module snoop_bus (
    input  logic                                              clk_i,
    input  logic                                              nreset_i,
    input  logic [bus_pkg::NUM_CACHES-1:0]                    cb_valid_i,
    input  bus_pkg::bus_req_type_t [bus_pkg::NUM_CACHES-1:0]  cb_req_type_i,
    input  logic [bus_pkg::NUM_CACHES-1:0][bus_pkg::ADDR_W-1:0] cb_addr_i,
    input  logic [bus_pkg::NUM_CACHES-1:0][bus_pkg::DATA_W-1:0] cb_wdata_i,
    output logic [bus_pkg::NUM_CACHES-1:0]                    cb_yumi_o,
    input  logic [bus_pkg::NUM_CACHES-1:0]                    sb_wait_i,
    input  logic [bus_pkg::NUM_CACHES-1:0]                    sb_hit_i,
    output logic [bus_pkg::NUM_CACHES-1:0]                    sb_valid_o,
    output logic                                              sb_tx_begin_o,
    output logic [bus_pkg::ADDR_W-1:0]                        sb_addr_o,
    output bus_pkg::bus_req_type_t                            sb_req_type_o,
    input  logic                                              mem_ready_i,
    output logic                                              mem_valid_o,
    output logic                                              mem_we_o,
    output logic [bus_pkg::ADDR_W-1:0]                        mem_addr_o,
    output logic [bus_pkg::DATA_W-1:0]                        mem_wdata_o,
    input  logic                                              mem_valid_i,
    input  logic [bus_pkg::DATA_W-1:0]                        mem_data_i,
    output logic [bus_pkg::NUM_CACHES-1:0]                    cb_valid_o,
    output logic [bus_pkg::DATA_W-1:0]                        cb_data_o,
    output logic                                              cb_ld_ex_o
);

    import bus_pkg::*;

    logic                  grant_valid;
    logic [CACHE_ID_W-1:0] grant_id;
    logic                  out_full;
    logic                  out_empty;
    logic                  out_deq;
    logic [CACHE_ID_W-1:0] head_id;

    bus_arbiter u_arbiter (
        .clk_i         (clk_i),
        .nreset_i      (nreset_i),
        .cb_valid_i    (cb_valid_i),
        .out_full_i    (out_full),
        .out_deq_i     (out_deq),
        .done_id_i     (head_id),
        .grant_valid_o (grant_valid),
        .grant_id_o    (grant_id)
    );

    // granted cache ids waiting for the controller
    id_fifo #(
        .width_p (CACHE_ID_W)
    ) u_out_queue (
        .clk_i    (clk_i),
        .nreset_i (nreset_i),
        .wr_i     (grant_valid),
        .rd_i     (out_deq),
        .wdata_i  (grant_id),
        .rdata_o  (head_id),
        .full_o   (out_full),
        .empty_o  (out_empty)
    );

    bus_controller u_controller (
        .clk_i         (clk_i),
        .nreset_i      (nreset_i),
        .out_empty_i   (out_empty),
        .head_id_i     (head_id),
        .out_deq_o     (out_deq),
        .cb_req_type_i (cb_req_type_i),
        .cb_addr_i     (cb_addr_i),
        .cb_wdata_i    (cb_wdata_i),
        .sb_wait_i     (sb_wait_i),
        .sb_hit_i      (sb_hit_i),
        .sb_valid_o    (sb_valid_o),
        .sb_tx_begin_o (sb_tx_begin_o),
        .sb_addr_o     (sb_addr_o),
        .sb_req_type_o (sb_req_type_o),
        .mem_ready_i   (mem_ready_i),
        .mem_valid_o   (mem_valid_o),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_valid_i   (mem_valid_i),
        .mem_data_i    (mem_data_i),
        .cb_yumi_o     (cb_yumi_o),
        .cb_valid_o    (cb_valid_o),
        .cb_data_o     (cb_data_o),
        .cb_ld_ex_o    (cb_ld_ex_o)
    );

endmodule

`default_nettype wire

// ==== tb_snoop_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_snoop_bus;

    import bus_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int REQS_PER_CACHE = 25;
    localparam int TOTAL_REQS     = REQS_PER_CACHE * NUM_CACHES;

    // expected outcome of one read accepted at memory
    typedef struct packed {
        logic [CACHE_ID_W-1:0] id;
        bus_req_type_t         op;
        logic                  shared;
        logic [DATA_W-1:0]     data;
    } read_exp_t;

    logic                              clk_i;
    logic                              nreset_i;
    logic [NUM_CACHES-1:0]             cb_valid_i;
    bus_req_type_t [NUM_CACHES-1:0]    cb_req_type_i;
    logic [NUM_CACHES-1:0][ADDR_W-1:0] cb_addr_i;
    logic [NUM_CACHES-1:0][DATA_W-1:0] cb_wdata_i;
    logic [NUM_CACHES-1:0]             cb_yumi_o;
    logic [NUM_CACHES-1:0]             sb_wait_i;
    logic [NUM_CACHES-1:0]             sb_hit_i;
    logic [NUM_CACHES-1:0]             sb_valid_o;
    logic                              sb_tx_begin_o;
    logic [ADDR_W-1:0]                 sb_addr_o;
    bus_req_type_t                     sb_req_type_o;
    logic                              mem_ready_i;
    logic                              mem_valid_o;
    logic                              mem_we_o;
    logic [ADDR_W-1:0]                 mem_addr_o;
    logic [DATA_W-1:0]                 mem_wdata_o;
    logic                              mem_valid_i;
    logic [DATA_W-1:0]                 mem_data_i;
    logic [NUM_CACHES-1:0]             cb_valid_o;
    logic [DATA_W-1:0]                 cb_data_o;
    logic                              cb_ld_ex_o;

    read_exp_t             exp_q[$];
    read_exp_t             exp_head;
    logic                  exp_valid;
    logic [DATA_W-1:0]     mem_model [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]     ref_mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0]     resp_data_q[$];
    int                    resp_due_q[$];
    int                    cycle;
    int                    issued [NUM_CACHES];
    int                    wait_cnt [NUM_CACHES];
    int                    others_yumi [NUM_CACHES][NUM_CACHES];
    logic [NUM_CACHES-1:0] wait_resp;
    logic                  unfair;
    logic                  txn_shared;

    // DUT outputs sampled mid-cycle
    logic [NUM_CACHES-1:0] yumi_s, cbv_s, valid_s, sbv_s;
    logic                  tx_s, memv_s, we_s;
    logic [ADDR_W-1:0]     addr_s;
    logic [DATA_W-1:0]     wdata_s;

    snoop_bus uut (.*);

    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr ^ 32'h5a5a_0f0f, ~addr};
    endfunction

    function automatic logic requests_finished();
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (issued[c] < REQS_PER_CACHE || wait_resp[c] || cb_valid_i[c]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_failure(input string msg);
        $display("Simulation failed");
        $fatal(1, "CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (@(posedge clk_i) nreset_i |=> (cb_yumi_o == '0
        && cb_valid_o == '0 && sb_valid_o == '0 && !sb_tx_begin_o && !mem_valid_o))
        else report_failure("bus outputs active during or right after reset");
    a_mem_ready: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_o |-> mem_ready_i)
        else report_failure("mem_valid_o without mem_ready_i");
    a_snoop_done: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_o |-> (sb_wait_i & sb_valid_o) == '0)
        else report_failure("memory access while a snooper still waits");
    a_one_excluded: assert property (@(posedge clk_i) disable iff (nreset_i)
        |sb_valid_o |-> $onehot(~sb_valid_o) && (~sb_valid_o & cb_valid_i) != '0)
        else report_failure("snoop mask does not exclude exactly the requester");
    a_snoop_idle: assert property (@(posedge clk_i) disable iff (nreset_i)
        sb_valid_o == '0 |-> sb_addr_o == '0 && sb_req_type_o == op_load)
        else report_failure("snoop fields not zero while no snoop is active");
    a_resp_target: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_i |-> exp_valid && cb_valid_o[exp_head.id])
        else report_failure("read response routed to the wrong cache");
    a_resp_data: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_i |-> cb_data_o == exp_head.data)
        else report_failure("read data differs from memory contents");
    a_resp_shared: assert property (@(posedge clk_i) disable iff (nreset_i)
        mem_valid_i && exp_head.op == op_load |-> cb_ld_ex_o == !exp_head.shared)
        else report_failure("cb_ld_ex_o does not match snoop hits");
    a_fair: assert property (@(posedge clk_i) disable iff (nreset_i) !unfair)
        else report_failure("cache granted twice while another cache waited");

    for (genvar c = 0; c < NUM_CACHES; c++) begin : g_cache_chk
        a_snoop_fields: assert property (@(posedge clk_i) disable iff (nreset_i)
            |sb_valid_o && !sb_valid_o[c]
            |-> sb_addr_o == cb_addr_i[c] && sb_req_type_o == cb_req_type_i[c])
            else report_failure("snoop address or opcode differs from the request");
        a_upgrade: assert property (@(posedge clk_i) disable iff (nreset_i)
            cb_yumi_o[c] && cb_req_type_i[c] == op_up_exclusive
            |-> cb_valid_o[c] && !mem_valid_o)
            else report_failure("upgrade not answered directly");
        a_write_back: assert property (@(posedge clk_i) disable iff (nreset_i)
            cb_yumi_o[c] && cb_req_type_i[c] == op_write_back |-> mem_valid_o && mem_we_o
            && mem_addr_o == cb_addr_i[c] && mem_wdata_o == cb_wdata_i[c])
            else report_failure("write-back transfer mismatch");
        a_read_issue: assert property (@(posedge clk_i) disable iff (nreset_i)
            cb_yumi_o[c] && (cb_req_type_i[c] == op_load || cb_req_type_i[c] == op_ld_exclusive)
            |-> mem_valid_o && !mem_we_o && mem_addr_o == cb_addr_i[c])
            else report_failure("read transfer mismatch");
        a_no_stray_resp: assert property (@(posedge clk_i) disable iff (nreset_i)
            cb_valid_o[c] |-> (mem_valid_i && exp_valid && exp_head.id == c)
            || (cb_yumi_o[c] && cb_req_type_i[c] == op_up_exclusive))
            else report_failure("unexpected response pulse");
        a_yumi_requested: assert property (@(posedge clk_i) disable iff (nreset_i)
            cb_yumi_o[c] |-> cb_valid_i[c] && !sb_valid_o[c])
            else report_failure("yumi to a cache that is not the requester");
    end

    task automatic serve_memory();
        if (mem_valid_i) begin
            void'(exp_q.pop_front());
        end
        if (memv_s) begin
            if (we_s) begin
                mem_model[addr_s] = wdata_s;
            end else begin
                resp_data_q.push_back(mem_model.exists(addr_s) ? mem_model[addr_s]
                                                               : fill_word(addr_s));
                resp_due_q.push_back(cycle + $urandom_range(1, 6));
            end
        end
        // answers leave strictly in acceptance order
        mem_valid_i = 1'b0;
        if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
            mem_valid_i = 1'b1;
            mem_data_i  = resp_data_q.pop_front();
            void'(resp_due_q.pop_front());
        end
        mem_ready_i = $urandom_range(0, 3) != 0;
    endtask

    task automatic drive_caches();
        read_exp_t entry;
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (yumi_s[c]) begin
                issued[c]++;
                if (cb_req_type_i[c] == op_write_back) begin
                    ref_mem[cb_addr_i[c]] = cb_wdata_i[c];
                end else if (cb_req_type_i[c] != op_up_exclusive) begin
                    entry.id     = CACHE_ID_W'(c);
                    entry.op     = cb_req_type_i[c];
                    entry.shared = txn_shared;
                    entry.data   = ref_mem.exists(cb_addr_i[c]) ? ref_mem[cb_addr_i[c]]
                                                                : fill_word(cb_addr_i[c]);
                    exp_q.push_back(entry);
                    wait_resp[c] = 1'b1;
                end
                cb_valid_i[c] = 1'b0;
            end else if (wait_resp[c]) begin
                wait_resp[c] = !cbv_s[c];
            end else if (!cb_valid_i[c] && issued[c] < REQS_PER_CACHE
                         && $urandom_range(0, 2) == 0) begin
                cb_valid_i[c]    = 1'b1;
                cb_req_type_i[c] = bus_req_type_t'($urandom_range(0, 3));
                cb_addr_i[c]     = 32'h0000_1000 + 32'($urandom_range(0, 7)) * 8;
                cb_wdata_i[c]    = {$urandom, $urandom};
            end
        end
    endtask

    task automatic answer_snoops();
        for (int c = 0; c < NUM_CACHES; c++) begin
            if (tx_s) begin
                wait_cnt[c] = sbv_s[c] ? $urandom_range(0, 3) : 0;
                sb_hit_i[c] = sbv_s[c] && $urandom_range(0, 3) == 0;
            end else if (wait_cnt[c] != 0) begin
                wait_cnt[c]--;
            end
            sb_wait_i[c] = wait_cnt[c] != 0;
        end
        if (tx_s) begin
            txn_shared = |(sb_hit_i & sbv_s);
        end
    endtask

    task automatic track_fairness();
        for (int c = 0; c < NUM_CACHES; c++) begin
            for (int d = 0; d < NUM_CACHES; d++) begin
                if (!valid_s[c] || yumi_s[c]) begin
                    others_yumi[c][d] = 0;
                end else if (d != c && yumi_s[d]) begin
                    others_yumi[c][d]++;
                    unfair = unfair || others_yumi[c][d] > 1;
                end
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TOTAL_REQS * 200 * CLK_PERIOD);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before all requests completed");
    end

    initial begin
        void'($urandom(71));
        nreset_i    = 1'b1;
        cb_valid_i  = '0;
        cb_addr_i   = '0;
        cb_wdata_i  = '0;
        sb_wait_i   = '0;
        sb_hit_i    = '0;
        mem_ready_i = 1'b0;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        cycle       = 0;
        wait_resp   = '0;
        unfair      = 1'b0;
        txn_shared  = 1'b0;
        exp_valid   = 1'b0;
        exp_head    = '0;
        for (int c = 0; c < NUM_CACHES; c++) begin
            cb_req_type_i[c] = op_load;
            issued[c]        = 0;
            wait_cnt[c]      = 0;
            for (int d = 0; d < NUM_CACHES; d++) begin
                others_yumi[c][d] = 0;
            end
        end
        repeat (5) @(posedge clk_i);
        #2;
        nreset_i = 1'b0;
        while (!requests_finished()) begin
            @(negedge clk_i);
            yumi_s  = cb_yumi_o;
            cbv_s   = cb_valid_o;
            valid_s = cb_valid_i;
            sbv_s   = sb_valid_o;
            tx_s    = sb_tx_begin_o;
            memv_s  = mem_valid_o;
            we_s    = mem_we_o;
            addr_s  = mem_addr_o;
            wdata_s = mem_wdata_o;
            @(posedge clk_i);
            #2;
            cycle++;
            serve_memory();
            drive_caches();
            answer_snoops();
            track_fairness();
            exp_valid = exp_q.size() != 0;
            if (exp_valid) begin
                exp_head = exp_q[0];
            end
        end
        repeat (2) @(posedge clk_i);
        if (exp_q.size() != 0 || resp_data_q.size() != 0) begin
            report_failure("reads left without a response");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
bus_pkg.sv
priority_lru.sv
id_fifo.sv
bus_arbiter.sv
bus_controller.sv
snoop_bus.sv
tb_snoop_bus.sv
